// ==== mem_sys.f ====
src/mem_sys_pkg.sv
src/req_router.sv
src/inst_store.sv
src/data_store.sv
src/event_counter.sv
src/uart_tx.sv
src/mem_sys_top.sv
dv/mem_sys_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the memory subsystem testbench with Verilator and run it.

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --timescale 1ns/1ps --top-module mem_sys_tb \
	-f mem_sys.f -Mdir "$build_dir" -o mem_sys_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$build_dir/mem_sys_sim" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulation run returned status $status"
	exit 1
fi

if grep -q "^Simulation PASSED$" "$log"; then
	exit 0
fi
echo "Pass message not found in $log"
exit 1

// ==== dv/mem_sys_stim.txt ====
# kind addr data strobe expected (hex); load/write/read issue one request
# run drains and raises enb, report checks the UART counts, sync ends test <addr>
load 00000000 11223344 f 00000000
load 00000004 a5a5a5a5 f 00000000
load 00000008 deadbeef 0 00000000
run 0 0 0 0
read 00000000 0 0 11223344
read 00000004 0 0 a5a5a5a5
read 00000008 0 0 deadbeef
sync 2 0 0 0
write 00000100 01234567 f 00000000
write 00000100 000000aa 1 00000000
write 00000100 bbcc0000 c 00000000
write 00000100 ee0000ff 9 00000000
read 00000100 0 0 eecc45ff
sync 3 0 0 0
write 00000004 ffffffff f 00000000
read 00000004 0 0 a5a5a5a5
sync 4 0 0 0
write 00000140 cafef00d f 00000000
read 00000000 0 0 11223344
read 00000140 0 0 cafef00d
read 00000008 0 0 deadbeef
read 00000300 0 0 eecc45ff
read 00000004 0 0 a5a5a5a5
sync 5 0 0 0
report 0 0 0 0
sync 6 0 0 0

// ==== dv/mem_sys_tb.sv ====
`timescale 1ns/1ps

module mem_sys_tb;

	logic                  clk_cpu;
	logic                  rst;
	logic                  enb;
	logic                  report;
	mem_sys_pkg::mem_req_t req;
	mem_sys_pkg::mem_rsp_t rsp;
	logic                  tx;

	logic [31:0] exp_q[$];
	int          issue_q[$]; // Cycle of each outstanding request.
	int          cycle;
	int          errors;
	int          checks;
	int          mon_errors;
	int          mon_checks;
	int          test_base;
	int          n_inst_rd;
	int          n_data_rd;
	int          n_data_wr;

	mem_sys_top i_dut (
		.clk_cpu(clk_cpu), .rst(rst), .enb(enb), .req(req),
		.rsp(rsp), .report(report), .tx(tx)
	);

	initial begin
		clk_cpu = 1'b0;
		forever #4 clk_cpu = ~clk_cpu;
	end

	always @(posedge clk_cpu)
		cycle <= cycle + 1;

	// Responses return in order two cycles after the strobe.
	always @(negedge clk_cpu) begin
		logic [31:0] exp_word;
		int          at;
		if (!rst && rsp.ready === 1'b1) begin
			if (exp_q.size() == 0) begin
				$display("Response arrived with no request outstanding at %0t", $time);
				mon_errors++;
			end else begin
				exp_word = exp_q.pop_front();
				at       = issue_q.pop_front();
				mon_checks++;
				if (rsp.rdata !== exp_word) begin
					$display("CHECK FAILED at %0t: rdata %h, expected %h",
						$time, rsp.rdata, exp_word);
					mon_errors++;
				end
				if (cycle - at != 2) begin
					$display("CHECK FAILED at %0t: ready %0d cycles after request, expected 2",
						$time, cycle - at);
					mon_errors++;
				end
			end
		end
	end

	function automatic int error_total();
		return errors + mon_errors;
	endfunction

	task automatic issue(input logic rd, input logic [31:0] addr, input logic [31:0] wdata,
			input logic [3:0] strb, input logic [31:0] exp_word);
		req.addr   = addr;
		req.wdata  = wdata;
		req.strobe = strb;
		req.read   = rd;
		req.write  = !rd;
		exp_q.push_back(exp_word);
		issue_q.push_back(cycle);
		if (rd && addr <= 32'hfc)
			n_inst_rd++;
		else if (rd)
			n_data_rd++;
		else if (addr > 32'hfc)
			n_data_wr++; // Instruction writes are not counted.
	endtask

	task automatic drain_responses();
		int waited;
		waited = 0;
		while (exp_q.size() != 0 && waited < 20) begin
			@(negedge clk_cpu);
			waited++;
		end
		if (exp_q.size() != 0) begin
			$display("Timed out at %0t with %0d responses missing", $time, exp_q.size());
			errors++;
			exp_q.delete();
			issue_q.delete();
		end
	endtask

	// Finds the start edge and samples at mid-bit.
	task automatic receive_byte(output logic [7:0] b, output logic ok);
		int waited;
		waited = 0;
		b      = '0;
		ok     = 1'b0;
		while (tx !== 1'b0 && waited < 40 * mem_sys_pkg::clks_per_bit) begin
			@(negedge clk_cpu);
			waited++;
		end
		if (tx === 1'b0) begin
			repeat (mem_sys_pkg::clks_per_bit / 2) @(negedge clk_cpu);
			for (int i = 0; i < 8; i++) begin
				repeat (mem_sys_pkg::clks_per_bit) @(negedge clk_cpu);
				b[i] = tx;
			end
			repeat (mem_sys_pkg::clks_per_bit) @(negedge clk_cpu);
			ok = (tx === 1'b1);
		end
	endtask

	task automatic check_report();
		logic [47:0] counts;
		logic [7:0]  b;
		logic        ok;
		int          quiet;
		drain_responses();
		counts = {n_data_wr[15:0], n_data_rd[15:0], n_inst_rd[15:0]};
		report = 1'b1;
		@(negedge clk_cpu);
		report = 1'b0;
		for (int i = 0; i < mem_sys_pkg::report_bytes; i++) begin
			receive_byte(b, ok);
			checks++;
			if (!ok) begin
				$display("No valid UART frame for report byte %0d at %0t", i, $time);
				errors++;
			end else if (b !== counts[8*i +: 8]) begin
				$display("CHECK FAILED at %0t: report byte %0d is %h, expected %h",
					$time, i, b, counts[8*i +: 8]);
				errors++;
			end
			if (i == 0) begin
				report = 1'b1; // Must be ignored mid-report.
				@(negedge clk_cpu);
				report = 1'b0;
			end
		end
		quiet = 0;
		while (tx === 1'b1 && quiet < 24 * mem_sys_pkg::clks_per_bit) begin
			@(negedge clk_cpu);
			quiet++;
		end
		if (tx !== 1'b1) begin
			$display("Extra UART frame after the report at %0t", $time);
			errors++;
		end
	endtask

	task automatic end_test(input int num);
		$display("Test %0d finished with %0d errors", num, error_total() - test_base);
		test_base = error_total();
	endtask

	initial begin
		int               fd;
		int               code;
		logic [63:0]      kind;
		logic [8*256-1:0] skip;
		logic [31:0]      addr;
		logic [31:0]      data;
		logic [31:0]      exp_word;
		logic [3:0]       strb;
		rst    = 1'b1;
		enb    = 1'b0;
		report = 1'b0;
		req    = '0;
		repeat (10) @(negedge clk_cpu);
		rst = 1'b0;
		for (int i = 0; i < 20; i++) begin
			@(negedge clk_cpu);
			checks++;
			if (tx !== 1'b1 || rsp.ready !== 1'b0) begin
				$display("CHECK FAILED at %0t: tx %b ready %b while idle", $time, tx, rsp.ready);
				errors++;
			end
		end
		end_test(1);
		fd = $fopen("dv/mem_sys_stim.txt", "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file");
			errors++;
		end else begin
			while (!$feof(fd)) begin
				code = $fscanf(fd, "%s", kind);
				if (code == 1 && kind == 64'("#")) begin
					code = $fgets(skip, fd);
				end else if (code == 1) begin
					code = $fscanf(fd, "%h %h %h %h", addr, data, strb, exp_word);
					@(negedge clk_cpu);
					req.read  = 1'b0;
					req.write = 1'b0;
					if (code != 4) begin
						$display("Malformed stimulus line at %0t", $time);
						errors++;
					end else if (kind == 64'("load")) begin
						enb = 1'b0;
						issue(1'b0, addr, data, strb, exp_word);
					end else if (kind == 64'("run")) begin
						drain_responses(); // Loads must land before enb rises.
						enb = 1'b1;
					end else if (kind == 64'("read")) begin
						issue(1'b1, addr, data, strb, exp_word);
					end else if (kind == 64'("write")) begin
						issue(1'b0, addr, data, strb, exp_word);
					end else if (kind == 64'("report")) begin
						check_report();
					end else if (kind == 64'("sync")) begin
						drain_responses();
						end_test(int'(addr));
					end else begin
						$display("Unknown stimulus kind at %0t", $time);
						errors++;
					end
				end
			end
			$fclose(fd);
		end
		drain_responses();
		$display("Checks %0d, errors %0d; inst reads %0d, data reads %0d, data writes %0d",
			checks + mon_checks, error_total(), n_inst_rd, n_data_rd, n_data_wr);
		if (error_total() == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// ==== src/mem_sys_top.sv ====
`timescale 1ns/1ps

module mem_sys_top (
	input  logic                  clk_cpu,
	input  logic                  rst,
	input  logic                  enb,
	input  mem_sys_pkg::mem_req_t req,
	output mem_sys_pkg::mem_rsp_t rsp,
	input  logic                  report,
	output logic                  tx
);

	mem_sys_pkg::mem_req_t inst_req;
	mem_sys_pkg::mem_rsp_t inst_rsp;
	mem_sys_pkg::mem_req_t data_req;
	mem_sys_pkg::mem_rsp_t data_rsp;
	logic       ev_inst_read;
	logic       ev_data_read;
	logic       ev_data_write;
	logic [7:0] tx_byte;
	logic       tx_start;
	logic       tx_busy;

	req_router u_router (
		.clk_cpu(clk_cpu), .rst(rst), .req(req),
		.inst_req(inst_req), .inst_rsp(inst_rsp),
		.data_req(data_req), .data_rsp(data_rsp), .rsp(rsp),
		.ev_inst_read(ev_inst_read), .ev_data_read(ev_data_read),
		.ev_data_write(ev_data_write)
	);

	inst_store u_inst_store (.clk_cpu(clk_cpu), .rst(rst), .enb(enb), .req(inst_req), .rsp(inst_rsp));

	data_store u_data_store (.clk_cpu(clk_cpu), .rst(rst), .req(data_req), .rsp(data_rsp));

	event_counter u_event_counter (
		.clk_cpu(clk_cpu), .rst(rst),
		.ev_inst_read(ev_inst_read), .ev_data_read(ev_data_read),
		.ev_data_write(ev_data_write), .report(report), .tx_busy(tx_busy),
		.tx_byte(tx_byte), .tx_start(tx_start)
	);

	uart_tx u_uart_tx (
		.clk_cpu(clk_cpu), .rst(rst), .tx_byte(tx_byte),
		.tx_start(tx_start), .tx_busy(tx_busy), .tx(tx)
	);

endmodule

// ==== src/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx (
	input  logic       clk_cpu,
	input  logic       rst,
	input  logic [7:0] tx_byte,
	input  logic       tx_start,
	output logic       tx_busy,
	output logic       tx
);

	typedef enum logic [1:0] {
		idle,
		start,
		data,
		stop
	} state_e;

	state_e state;
	logic [$clog2(mem_sys_pkg::clks_per_bit)-1:0] cnt; // Cycles into the current bit.
	logic [2:0] bit_idx;
	logic [7:0] shift;
	logic       bit_done;

	assign bit_done = (int'(cnt) == mem_sys_pkg::clks_per_bit - 1);

	always_ff @(posedge clk_cpu) begin
		if (rst) begin
			state   <= idle;
			cnt     <= '0;
			bit_idx <= '0;
		end else begin
			cnt <= (state == idle || bit_done) ? '0 : cnt + 1'b1;
			case (state)
				idle: if (tx_start) begin
					shift   <= tx_byte;
					bit_idx <= '0;
					state   <= start;
				end
				start: if (bit_done) state <= data;
				data: if (bit_done) begin
					shift   <= shift >> 1; // LSB first.
					bit_idx <= bit_idx + 1'b1;
					if (bit_idx == 3'd7)
						state <= stop;
				end
				stop: if (bit_done) state <= idle;
				default: state <= idle;
			endcase
		end
	end

	assign tx_busy = (state != idle);

	always_comb begin
		case (state)
			start:   tx = 1'b0;
			data:    tx = shift[0];
			default: tx = 1'b1; // Idle and stop bit.
		endcase
	end

endmodule

// ==== src/event_counter.sv ====
`timescale 1ns/1ps

module event_counter (
	input  logic       clk_cpu,
	input  logic       rst,
	input  logic       ev_inst_read,
	input  logic       ev_data_read,
	input  logic       ev_data_write,
	input  logic       report,
	input  logic       tx_busy,
	output logic [7:0] tx_byte,
	output logic       tx_start
);

	typedef enum logic [1:0] {
		idle,
		send,
		wait_busy
	} state_e;

	state_e state;
	logic [15:0] cnt_ir;
	logic [15:0] cnt_dr;
	logic [15:0] cnt_dw;
	logic [47:0] snap; // Data writes, data reads, inst reads from the top down.
	logic [$clog2(mem_sys_pkg::report_bytes)-1:0] idx;

	function automatic logic [15:0] sat_inc(input logic [15:0] cnt, input logic ev);
		if (ev && cnt != 16'hffff)
			return cnt + 16'd1;
		return cnt;
	endfunction

	always_ff @(posedge clk_cpu) begin
		if (rst) begin
			cnt_ir <= '0;
			cnt_dr <= '0;
			cnt_dw <= '0;
		end else begin
			cnt_ir <= sat_inc(cnt_ir, ev_inst_read);
			cnt_dr <= sat_inc(cnt_dr, ev_data_read);
			cnt_dw <= sat_inc(cnt_dw, ev_data_write);
		end
	end

	always_ff @(posedge clk_cpu) begin
		if (rst) begin
			state <= idle;
			idx   <= '0;
		end else begin
			case (state)
				idle: if (report) begin // Strobes during a report fall here only when idle.
					snap  <= {cnt_dw, cnt_dr, cnt_ir};
					idx   <= '0;
					state <= send;
				end
				send: state <= wait_busy;
				wait_busy: if (!tx_busy) begin
					if (int'(idx) == mem_sys_pkg::report_bytes - 1) begin
						state <= idle;
					end else begin
						idx   <= idx + 1'b1;
						state <= send;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	assign tx_start = (state == send);
	assign tx_byte  = snap[8*idx +: 8];

endmodule

// ==== src/data_store.sv ====
`timescale 1ns/1ps

module data_store (
	input  logic                  clk_cpu,
	input  logic                  rst,
	input  mem_sys_pkg::mem_req_t req,
	output mem_sys_pkg::mem_rsp_t rsp
);

	logic [31:0] mem [mem_sys_pkg::data_words];
	logic [$clog2(mem_sys_pkg::data_words)-1:0] idx;

	// Upper address bits are not decoded.
	assign idx = req.addr[2 +: $clog2(mem_sys_pkg::data_words)];

	initial begin
		for (int i = 0; i < mem_sys_pkg::data_words; i++)
			mem[i] = '0;
	end

	// One byte lane per strobe bit.
	always_ff @(posedge clk_cpu) begin
		if (req.write) begin
			for (int lane = 0; lane < 4; lane++) begin
				if (req.strobe[lane])
					mem[idx][8*lane +: 8] <= req.wdata[8*lane +: 8];
			end
		end
	end

	always_ff @(posedge clk_cpu) begin
		if (rst) begin
			rsp.ready <= 1'b0;
		end else begin
			rsp.ready <= req.read | req.write;
			rsp.rdata <= req.read ? mem[idx] : '0;
		end
	end

endmodule

// ==== src/inst_store.sv ====
`timescale 1ns/1ps

module inst_store (
	input  logic                  clk_cpu,
	input  logic                  rst,
	input  logic                  enb,
	input  mem_sys_pkg::mem_req_t req,
	output mem_sys_pkg::mem_rsp_t rsp
);

	logic [31:0] mem [mem_sys_pkg::inst_words];
	logic [$clog2(mem_sys_pkg::inst_words)-1:0] idx;

	assign idx = req.addr[2 +: $clog2(mem_sys_pkg::inst_words)];

	initial begin
		for (int i = 0; i < mem_sys_pkg::inst_words; i++)
			mem[i] = '0;
	end

	// Load phase only; strobe is ignored.
	always_ff @(posedge clk_cpu) begin
		if (req.write && !enb)
			mem[idx] <= req.wdata;
	end

	// Dropped writes are answered too.
	always_ff @(posedge clk_cpu) begin
		if (rst) begin
			rsp.ready <= 1'b0;
		end else begin
			rsp.ready <= req.read | req.write;
			rsp.rdata <= req.read ? mem[idx] : '0; // Writes answer zero.
		end
	end

endmodule

// ==== src/req_router.sv ====
`timescale 1ns/1ps

module req_router (
	input  logic                  clk_cpu,
	input  logic                  rst,
	input  mem_sys_pkg::mem_req_t req,
	output mem_sys_pkg::mem_req_t inst_req,
	input  mem_sys_pkg::mem_rsp_t inst_rsp,
	output mem_sys_pkg::mem_req_t data_req,
	input  mem_sys_pkg::mem_rsp_t data_rsp,
	output mem_sys_pkg::mem_rsp_t rsp,
	output logic                  ev_inst_read,
	output logic                  ev_data_read,
	output logic                  ev_data_write
);

	mem_sys_pkg::mem_req_t req_q;
	mem_sys_pkg::region_e  region_d;
	mem_sys_pkg::region_e  region_q;  // Region of the request being forwarded.
	mem_sys_pkg::region_e  region_q2; // Region of the request being answered.

	assign region_d = (req.addr <= mem_sys_pkg::end_inst) ?
		mem_sys_pkg::region_inst : mem_sys_pkg::region_data;

	always_ff @(posedge clk_cpu) begin
		if (rst) begin
			req_q.read  <= 1'b0;
			req_q.write <= 1'b0;
			region_q    <= mem_sys_pkg::region_inst;
			region_q2   <= mem_sys_pkg::region_inst;
		end else begin
			req_q     <= req;
			region_q  <= region_d;
			region_q2 <= region_q;
		end
	end

	// Only the selected store sees the strobes.
	always_comb begin
		inst_req       = req_q;
		inst_req.read  = req_q.read & (region_q == mem_sys_pkg::region_inst);
		inst_req.write = req_q.write & (region_q == mem_sys_pkg::region_inst);
		data_req       = req_q;
		data_req.read  = req_q.read & (region_q == mem_sys_pkg::region_data);
		data_req.write = req_q.write & (region_q == mem_sys_pkg::region_data);
	end

	// Instruction writes are load traffic and raise no event.
	assign ev_inst_read  = inst_req.read;
	assign ev_data_read  = data_req.read;
	assign ev_data_write = data_req.write;

	// Steered by the region of the answered request, so mixed
	// back-to-back traffic returns the right store's word.
	always_comb begin
		if (region_q2 == mem_sys_pkg::region_inst)
			rsp = inst_rsp;
		else
			rsp = data_rsp;
	end

endmodule

// ==== src/mem_sys_pkg.sv ====
package mem_sys_pkg;

	// Memory map. Instruction region is 0x000 to end_inst.
	localparam logic [31:0] end_inst = 32'h0000_00fc;
	localparam int inst_words = 64;

	// Data region starts above end_inst; high addresses alias into the store.
	localparam int data_words = 64;

	// Bit time kept short for simulation.
	localparam int clks_per_bit = 8;

	// Three 16-bit counts, low byte first.
	localparam int report_bytes = 6;

	typedef enum logic {
		region_inst,
		region_data
	} region_e;

	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [3:0]  strobe; // Bit 0 strobes the low byte.
		logic        read;
		logic        write;
	} mem_req_t;

	typedef struct packed {
		logic [31:0] rdata;
		logic        ready;
	} mem_rsp_t;

endpackage
